// ==== Bender.yml ====
package:
  name: decode_controller

sources:
  - rtl/ctrl_pkg.sv
  - rtl/opcode_decoder.sv
  - rtl/control_table.sv
  - rtl/branch_resolver.sv
  - rtl/decode_controller.sv
  - target: test
    files:
      - testbench/tb_decode_controller.sv

// ==== project.f ====
rtl/ctrl_pkg.sv
rtl/opcode_decoder.sv
rtl/control_table.sv
rtl/branch_resolver.sv
rtl/decode_controller.sv
testbench/tb_decode_controller.sv

// ==== rtl/branch_resolver.sv ====
// ==============================
// branch decision for the slot after a B or B.LT
// same result whatever the current instruction is
// ==============================

`default_nettype none

module branch_resolver (
    input  var logic negative,
    input  var logic overflow,
    input  var logic negative_alu,
    input  var logic overflow_alu,
    input  var logic setflags_ex,
    input  var logic blt_rf,
    input  var logic b_rf,
    output logic     brtaken
);

    logic n_sel;
    logic v_sel;
    logic lt_cond;

    // forward from execute when it is about to write the flags
    assign n_sel = setflags_ex ? negative_alu : negative;
    assign v_sel = setflags_ex ? overflow_alu : overflow;

    // signed less than, N != V
    assign lt_cond = n_sel ^ v_sel;

    // B.LT wins over B, otherwise B is always taken
    assign brtaken = blt_rf ? lt_cond : b_rf;

endmodule

`default_nettype wire

// ==== rtl/control_table.sv ====
// ==============================
// opcode to datapath control word, purely combinational
// unlisted controls are 0, aluop defaults to pass b
// ==============================

`default_nettype none

module control_table (
    input  ctrl_pkg::opcode_e op,
    output ctrl_pkg::aluop_e  aluop,
    output logic              reg2loc,
    output logic              regwr,
    output logic              alusrc,
    output logic              addi,
    output logic              byteop,
    output logic              setflags,
    output logic              setzeroflag,
    output logic              mov,
    output logic              memwr,
    output logic              mem2reg,
    output logic              movk,
    output logic              uncondbr,
    output logic              cbz,
    output logic              blt,
    output logic              b
);

    always_comb begin
        // idle control word, also what op_nop gets
        aluop       = ctrl_pkg::alu_pass_b;
        reg2loc     = 1'b0;
        regwr       = 1'b0;
        alusrc      = 1'b0;
        addi        = 1'b0;
        byteop      = 1'b0;
        setflags    = 1'b0;
        setzeroflag = 1'b0;
        mov         = 1'b0;
        memwr       = 1'b0;
        mem2reg     = 1'b0;
        movk        = 1'b0;
        uncondbr    = 1'b0;
        cbz         = 1'b0;
        blt         = 1'b0;
        b           = 1'b0;

        case (op)
            ctrl_pkg::op_addi: begin
                aluop = ctrl_pkg::alu_add;
                regwr = 1'b1;
                addi  = 1'b1;
            end
            ctrl_pkg::op_adds: begin
                aluop    = ctrl_pkg::alu_add;
                regwr    = 1'b1;
                alusrc   = 1'b1;
                setflags = 1'b1;
            end
            ctrl_pkg::op_subs: begin
                aluop    = ctrl_pkg::alu_sub;
                regwr    = 1'b1;
                alusrc   = 1'b1;
                setflags = 1'b1;
            end
            ctrl_pkg::op_b: begin
                uncondbr = 1'b1;
                b        = 1'b1;
            end
            ctrl_pkg::op_blt: begin
                // condition is resolved one slot later
                blt = 1'b1;
            end
            ctrl_pkg::op_cbz: begin
                // register passes through the ALU for the zero test
                reg2loc     = 1'b1;
                alusrc      = 1'b1;
                setzeroflag = 1'b1;
                cbz         = 1'b1;
            end
            ctrl_pkg::op_ldur: begin
                aluop   = ctrl_pkg::alu_add;
                regwr   = 1'b1;
                mem2reg = 1'b1;
            end
            ctrl_pkg::op_ldurb: begin
                aluop   = ctrl_pkg::alu_add;
                regwr   = 1'b1;
                byteop  = 1'b1;
                mem2reg = 1'b1;
            end
            ctrl_pkg::op_stur: begin
                aluop   = ctrl_pkg::alu_add;
                reg2loc = 1'b1;
                memwr   = 1'b1;
            end
            ctrl_pkg::op_sturb: begin
                aluop   = ctrl_pkg::alu_add;
                reg2loc = 1'b1;
                byteop  = 1'b1;
                memwr   = 1'b1;
            end
            ctrl_pkg::op_movk: begin
                // keep the other halfwords of rd
                reg2loc = 1'b1;
                regwr   = 1'b1;
                alusrc  = 1'b1;
                mov     = 1'b1;
                movk    = 1'b1;
            end
            ctrl_pkg::op_movz: begin
                reg2loc = 1'b1;
                regwr   = 1'b1;
                alusrc  = 1'b1;
                mov     = 1'b1;
            end
            default: begin
                // op_nop, defaults stand
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/ctrl_pkg.sv ====
// ==============================
// shared types and opcode patterns for the decode controller
// patterns are matched from bit 31 down and must not overlap
// ==============================

`default_nettype none

package ctrl_pkg;

    // instruction word in register-fetch
    localparam int instr_width = 32;

    // decoded instruction, op_nop covers every unknown encoding
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_addi  = 4'd1,
        op_adds  = 4'd2,
        op_subs  = 4'd3,
        op_b     = 4'd4,
        op_blt   = 4'd5,
        op_cbz   = 4'd6,
        op_ldur  = 4'd7,
        op_ldurb = 4'd8,
        op_stur  = 4'd9,
        op_sturb = 4'd10,
        op_movk  = 4'd11,
        op_movz  = 4'd12
    } opcode_e;

    // ALU operation as the datapath expects it
    typedef enum logic [2:0] {
        alu_pass_b = 3'b000,
        alu_add    = 3'b010,
        alu_sub    = 3'b011
    } aluop_e;

    // I-type, field is bits 31..22
    localparam logic [9:0] opc_addi = 10'b1001000100;

    // R-type flag setting, bits 31..21
    localparam logic [10:0] opc_adds = 11'b10101011000;
    localparam logic [10:0] opc_subs = 11'b11101011000;

    // unconditional branch, bits 31..26
    localparam logic [5:0] opc_b = 6'b000101;

    // conditional branches, bits 31..24
    localparam logic [7:0] opc_blt = 8'b01010100;
    localparam logic [7:0] opc_cbz = 8'b10110100;

    // D-type loads and stores, bits 31..21
    localparam logic [10:0] opc_ldur  = 11'b11111000010;
    localparam logic [10:0] opc_ldurb = 11'b00111000010;
    localparam logic [10:0] opc_stur  = 11'b11111000000;
    localparam logic [10:0] opc_sturb = 11'b00111000000;

    // IM-type wide moves, bits 31..23
    localparam logic [8:0] opc_movk = 9'b111100101;
    localparam logic [8:0] opc_movz = 9'b110100101;

endpackage

`default_nettype wire

// ==== rtl/decode_controller.sv ====
// ==============================
// decode-stage controller top, no state and no clock
// all outputs settle in the same cycle as the inputs
// ==============================

`default_nettype none

module decode_controller (
    input  var logic [ctrl_pkg::instr_width-1:0] instruction,
    input  var logic                             negative,
    input  var logic                             overflow,
    input  var logic                             negative_alu,
    input  var logic                             overflow_alu,
    input  var logic                             setflags_ex,
    input  var logic                             blt_rf,
    input  var logic                             b_rf,
    output ctrl_pkg::aluop_e                     aluop,
    output logic                                 reg2loc,
    output logic                                 regwr,
    output logic                                 alusrc,
    output logic                                 addi,
    output logic                                 byteop,
    output logic                                 setflags,
    output logic                                 setzeroflag,
    output logic                                 mov,
    output logic                                 memwr,
    output logic                                 mem2reg,
    output logic                                 movk,
    output logic                                 uncondbr,
    output logic                                 brtaken,
    output logic                                 cbz,
    output logic                                 blt,
    output logic                                 b
);

    ctrl_pkg::opcode_e op;

    opcode_decoder decoder_i (
        .instruction (instruction),
        .op          (op)
    );

    control_table table_i (
        .op          (op),
        .aluop       (aluop),
        .reg2loc     (reg2loc),
        .regwr       (regwr),
        .alusrc      (alusrc),
        .addi        (addi),
        .byteop      (byteop),
        .setflags    (setflags),
        .setzeroflag (setzeroflag),
        .mov         (mov),
        .memwr       (memwr),
        .mem2reg     (mem2reg),
        .movk        (movk),
        .uncondbr    (uncondbr),
        .cbz         (cbz),
        .blt         (blt),
        .b           (b)
    );

    // independent of the decoded opcode
    branch_resolver resolver_i (
        .negative     (negative),
        .overflow     (overflow),
        .negative_alu (negative_alu),
        .overflow_alu (overflow_alu),
        .setflags_ex  (setflags_ex),
        .blt_rf       (blt_rf),
        .b_rf         (b_rf),
        .brtaken      (brtaken)
    );

endmodule

`default_nettype wire

// ==== rtl/opcode_decoder.sv ====
// ==============================
// combinational opcode decode of the register-fetch word
// anything that matches no pattern decodes to op_nop
// ==============================

`default_nettype none

module opcode_decoder (
    input  var logic [ctrl_pkg::instr_width-1:0] instruction,
    output ctrl_pkg::opcode_e                    op
);

    localparam int msb = ctrl_pkg::instr_width - 1;

    // high fields of the word, one per pattern length
    logic [5:0]  field_b;
    logic [7:0]  field_cb;
    logic [8:0]  field_im;
    logic [9:0]  field_i;
    logic [10:0] field_rd;

    assign field_b  = instruction[msb -: 6];
    assign field_cb = instruction[msb -: 8];
    assign field_im = instruction[msb -: 9];
    assign field_i  = instruction[msb -: 10];
    assign field_rd = instruction[msb -: 11];

    // patterns are disjoint, so the order here is free
    always_comb begin
        op = ctrl_pkg::op_nop;

        if (field_i == ctrl_pkg::opc_addi) begin
            op = ctrl_pkg::op_addi;
        end else if (field_rd == ctrl_pkg::opc_adds) begin
            op = ctrl_pkg::op_adds;
        end else if (field_rd == ctrl_pkg::opc_subs) begin
            op = ctrl_pkg::op_subs;
        end else if (field_b == ctrl_pkg::opc_b) begin
            op = ctrl_pkg::op_b;
        end else if (field_cb == ctrl_pkg::opc_blt) begin
            op = ctrl_pkg::op_blt;
        end else if (field_cb == ctrl_pkg::opc_cbz) begin
            op = ctrl_pkg::op_cbz;
        end else if (field_rd == ctrl_pkg::opc_ldur) begin
            op = ctrl_pkg::op_ldur;
        end else if (field_rd == ctrl_pkg::opc_ldurb) begin
            op = ctrl_pkg::op_ldurb;
        end else if (field_rd == ctrl_pkg::opc_stur) begin
            op = ctrl_pkg::op_stur;
        end else if (field_rd == ctrl_pkg::opc_sturb) begin
            op = ctrl_pkg::op_sturb;
        end else if (field_im == ctrl_pkg::opc_movk) begin
            op = ctrl_pkg::op_movk;
        end else if (field_im == ctrl_pkg::opc_movz) begin
            op = ctrl_pkg::op_movz;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_decode_controller.sv ====
// ==============================
// self-checking testbench for decode_controller
// DUT is combinational, clk and rst only pace the stimulus
// stops at the first mismatch
// ==============================

`default_nettype none

module tb_decode_controller;

    timeunit 1ns;
    timeprecision 10ps;

    // vectors per test group
    localparam int per_instr_reps = 8;
    localparam int num_each_instr = 12 * per_instr_reps;
    localparam int num_unknown    = 32;
    localparam int num_blt_plain  = 16;
    localparam int num_blt_fwd    = 16;
    localparam int num_uncond     = 26;
    localparam int num_soak       = 2000;
    localparam int num_vectors    = num_each_instr + num_unknown + num_blt_plain
                                    + num_blt_fwd + num_uncond + num_soak;

    logic        clk;
    logic        rst;
    logic [31:0] instruction;
    logic        negative;
    logic        overflow;
    logic        negative_alu;
    logic        overflow_alu;
    logic        setflags_ex;
    logic        blt_rf;
    logic        b_rf;

    ctrl_pkg::aluop_e aluop;
    logic reg2loc, regwr, alusrc, addi, byteop, setflags, setzeroflag, mov;
    logic memwr, mem2reg, movk, uncondbr, brtaken, cbz, blt, b;

    logic [31:0] rng_state;
    logic        vec_valid;

    decode_controller dut_i (
        .instruction  (instruction),
        .negative     (negative),
        .overflow     (overflow),
        .negative_alu (negative_alu),
        .overflow_alu (overflow_alu),
        .setflags_ex  (setflags_ex),
        .blt_rf       (blt_rf),
        .b_rf         (b_rf),
        .aluop        (aluop),
        .reg2loc      (reg2loc),
        .regwr        (regwr),
        .alusrc       (alusrc),
        .addi         (addi),
        .byteop       (byteop),
        .setflags     (setflags),
        .setzeroflag  (setzeroflag),
        .mov          (mov),
        .memwr        (memwr),
        .mem2reg      (mem2reg),
        .movk         (movk),
        .uncondbr     (uncondbr),
        .brtaken      (brtaken),
        .cbz          (cbz),
        .blt          (blt),
        .b            (b)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // kind 0 is unknown, 1..12 follow the instruction list order
    function automatic int instr_kind(input logic [31:0] w);
        if (w[31:22] == 10'b1001000100) return 1;
        if (w[31:21] == 11'b10101011000) return 2;
        if (w[31:21] == 11'b11101011000) return 3;
        if (w[31:26] == 6'b000101) return 4;
        if (w[31:24] == 8'b01010100) return 5;
        if (w[31:24] == 8'b10110100) return 6;
        if (w[31:21] == 11'b11111000010) return 7;
        if (w[31:21] == 11'b00111000010) return 8;
        if (w[31:21] == 11'b11111000000) return 9;
        if (w[31:21] == 11'b00111000000) return 10;
        if (w[31:23] == 9'b111100101) return 11;
        if (w[31:23] == 9'b110100101) return 12;
        return 0;
    endfunction

    // pattern field on top, random bits below it
    function automatic logic [31:0] pattern_word(input int kind, input logic [31:0] r);
        case (kind)
            1:  return {10'b1001000100, r[21:0]};
            2:  return {11'b10101011000, r[20:0]};
            3:  return {11'b11101011000, r[20:0]};
            4:  return {6'b000101, r[25:0]};
            5:  return {8'b01010100, r[23:0]};
            6:  return {8'b10110100, r[23:0]};
            7:  return {11'b11111000010, r[20:0]};
            8:  return {11'b00111000010, r[20:0]};
            9:  return {11'b11111000000, r[20:0]};
            10: return {11'b00111000000, r[20:0]};
            11: return {9'b111100101, r[22:0]};
            12: return {9'b110100101, r[22:0]};
            default: return r;
        endcase
    endfunction

    // expected {aluop, 15 controls, brtaken}
    function automatic logic [18:0] expected_outputs(
        input logic [31:0] instr,
        input logic n, input logic v, input logic n_alu, input logic v_alu,
        input logic sf_ex, input logic blt_prev, input logic b_prev
    );
        logic [17:0] ctl;
        logic        n_use;
        logic        v_use;
        logic        taken;
        // aluop, then reg2loc regwr alusrc addi / byteop setflags setzeroflag mov
        // then memwr mem2reg movk uncondbr / cbz blt b
        case (instr_kind(instr))
            1:  ctl = {3'b010, 15'b0101_0000_0000_000};
            2:  ctl = {3'b010, 15'b0110_0100_0000_000};
            3:  ctl = {3'b011, 15'b0110_0100_0000_000};
            4:  ctl = {3'b000, 15'b0000_0000_0001_001};
            5:  ctl = {3'b000, 15'b0000_0000_0000_010};
            6:  ctl = {3'b000, 15'b1010_0010_0000_100};
            7:  ctl = {3'b010, 15'b0100_0000_0100_000};
            8:  ctl = {3'b010, 15'b0100_1000_0100_000};
            9:  ctl = {3'b010, 15'b1000_0000_1000_000};
            10: ctl = {3'b010, 15'b1000_1000_1000_000};
            11: ctl = {3'b000, 15'b1110_0001_0010_000};
            12: ctl = {3'b000, 15'b1110_0001_0000_000};
            default: ctl = 18'b0;
        endcase
        // flags come from execute when it sets them this cycle
        n_use = sf_ex ? n_alu : n;
        v_use = sf_ex ? v_alu : v;
        taken = blt_prev ? (n_use != v_use) : b_prev;
        return {ctl, taken};
    endfunction

    task automatic check_value(input string name, input logic [2:0] actual,
                               input logic [2:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_outputs();
        logic [18:0] exp;
        exp = expected_outputs(instruction, negative, overflow, negative_alu,
                               overflow_alu, setflags_ex, blt_rf, b_rf);
        check_value("aluop", aluop, exp[18:16]);
        check_value("reg2loc", reg2loc, exp[15]);
        check_value("regwr", regwr, exp[14]);
        check_value("alusrc", alusrc, exp[13]);
        check_value("addi", addi, exp[12]);
        check_value("byteop", byteop, exp[11]);
        check_value("setflags", setflags, exp[10]);
        check_value("setzeroflag", setzeroflag, exp[9]);
        check_value("mov", mov, exp[8]);
        check_value("memwr", memwr, exp[7]);
        check_value("mem2reg", mem2reg, exp[6]);
        check_value("movk", movk, exp[5]);
        check_value("uncondbr", uncondbr, exp[4]);
        check_value("cbz", cbz, exp[3]);
        check_value("blt", blt, exp[2]);
        check_value("b", b, exp[1]);
        check_value("brtaken", brtaken, exp[0]);
    endtask

    task automatic random_of_kind(input int kind, output logic [31:0] w);
        logic [31:0] r;
        draw_random(r);
        if (kind == 0) begin
            // redraw until nothing matches
            while (instr_kind(r) != 0) begin
                draw_random(r);
            end
            w = r;
        end else begin
            w = pattern_word(kind, r);
        end
    endtask

    // one vector, driven 1 ns after the rising edge
    task automatic drive_vector(input logic [31:0] instr, input logic [6:0] side);
        @(posedge clk);
        #1;
        instruction  = instr;
        negative     = side[0];
        overflow     = side[1];
        negative_alu = side[2];
        overflow_alu = side[3];
        setflags_ex  = side[4];
        blt_rf       = side[5];
        b_rf         = side[6];
        vec_valid    = 1'b1;
    endtask

    // compare mid cycle, inputs settled since 1 ns after the edge
    initial begin
        forever begin
            @(posedge clk);
            #5;
            if (!rst && vec_valid) begin
                compare_outputs();
            end
        end
    end

    initial begin
        #((num_vectors + 20) * 10);
        $display("timeout: the test did not finish within %0d cycles", num_vectors + 20);
        $display("Errors found");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] w;
        logic [31:0] r;
        clk            = 1'b0;
        rst            = 1'b1;
        instruction    = '0;
        negative       = 1'b0;
        overflow       = 1'b0;
        negative_alu   = 1'b0;
        overflow_alu   = 1'b0;
        setflags_ex    = 1'b0;
        blt_rf         = 1'b0;
        b_rf           = 1'b0;
        vec_valid      = 1'b0;
        rng_state      = 32'h7d5ea19a;

        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        // every instruction with random low bits and side inputs
        for (int k = 1; k <= 12; k++) begin
            for (int i = 0; i < per_instr_reps; i++) begin
                random_of_kind(k, w);
                draw_random(r);
                drive_vector(w, r[6:0]);
            end
        end

        for (int i = 0; i < num_unknown; i++) begin
            random_of_kind(0, w);
            draw_random(r);
            drive_vector(w, r[6:0]);
        end

        // B.LT, flag register, ALU flags swept as well
        for (int c = 0; c < num_blt_plain; c++) begin
            draw_random(r);
            random_of_kind(r[31:28] % 13, w);
            drive_vector(w, {r[0], 1'b1, 1'b0, c[3:0]});
        end

        // B.LT with forwarding, flag register swept as well
        for (int c = 0; c < num_blt_fwd; c++) begin
            draw_random(r);
            random_of_kind(r[31:28] % 13, w);
            drive_vector(w, {r[0], 1'b1, 1'b1, c[3:0]});
        end

        // blt_rf low, brtaken follows b_rf for every kind
        for (int k = 0; k <= 12; k++) begin
            for (int bv = 0; bv < 2; bv++) begin
                random_of_kind(k, w);
                draw_random(r);
                drive_vector(w, {bv[0], 1'b0, r[4:0]});
            end
        end

        for (int i = 0; i < num_soak; i++) begin
            draw_random(r);
            random_of_kind(r[31:16] % 13, w);
            drive_vector(w, r[6:0]);
        end

        // let the last vector be checked
        @(posedge clk);
        #1 vec_valid = 1'b0;

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
